// ==== compile.f ====
+incdir+.
pf_addr_pkg.sv
pf_pred_pkg.sv
pf_table_ram.sv
next_addr_table.sv
usefulness_table.sv
prefetch_decide.sv
prefetch_predictor.sv
prefetch_predictor_sva.sv
tb_prefetch_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_prefetch_predictor -o sim_prefetch > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    cat build.log
    exit 1
fi

./obj_dir/sim_prefetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== tb_prefetch_predictor.sv ====
`timescale 1ns/10ps
`include "pf_config.svh"

module tb_prefetch_predictor;

    localparam int ENTRIES = 2 ** `PF_INDEX_WIDTH;

    logic clk = 1'b0;
    logic reset = 1'b1;
    pf_addr_pkg::addr_t addr = 32'h40;
    logic update_en = 1'b0;
    pf_addr_pkg::addr_t update_addr = '0;
    logic useful = 1'b0;
    logic anneal_miss = 1'b0;
    logic anneal_instr = 1'b0;
    pf_addr_pkg::addr_t anneal_addr = '0;
    logic req;
    pf_addr_pkg::addr_t pf_addr;

    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int seed = 32'ha620_9ba0;

    // reference model state
    pf_addr_pkg::addr_t m_succ [ENTRIES];
    logic               m_valid [ENTRIES];
    pf_pred_pkg::ctr2_t m_conf [ENTRIES];
    pf_pred_pkg::ctr2_t m_use [ENTRIES];
    pf_addr_pkg::addr_t m_prev;
    logic               m_pend;
    pf_addr_pkg::index_t m_pidx;
    pf_pred_pkg::ctr2_t m_pctr;

    localparam pf_addr_pkg::addr_t A = 32'h1000;
    localparam pf_addr_pkg::addr_t B = 32'h2004;
    localparam pf_addr_pkg::addr_t G = 32'h3008;
    localparam pf_addr_pkg::addr_t C = 32'h400c;

    prefetch_predictor prefetch_predictor_i (.*);

    always #10 clk = ~clk;

    function automatic pf_pred_pkg::ctr2_t sat_up(pf_pred_pkg::ctr2_t c);
        return (c == 2'b11) ? c : c + 2'b01;
    endfunction

    function automatic pf_pred_pkg::ctr2_t sat_down(pf_pred_pkg::ctr2_t c);
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    always @(posedge clk) begin : model
        logic miss, upd, fnew, e_req;
        pf_addr_pkg::addr_t e_pf;
        pf_addr_pkg::index_t ci, ui, ai, pi;
        ci = addr[`PF_INDEX_WIDTH-1:0];
        ui = update_addr[`PF_INDEX_WIDTH-1:0];
        ai = anneal_addr[`PF_INDEX_WIDTH-1:0];
        pi = m_prev[`PF_INDEX_WIDTH-1:0];
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                m_succ[i] = '0;
                m_valid[i] = 1'b0;
                m_conf[i] = `PF_CONF_INIT;
                m_use[i] = `PF_USE_INIT;
            end
            m_prev = addr;
            m_pend = 1'b0;
        end else begin
            fnew = (addr != m_prev);
            miss = anneal_miss && anneal_instr;
            // update port is lost to a miss read or a pending anneal write
            upd = update_en && !miss && !m_pend;
            e_req = 1'b0;
            e_pf = '0;
            if (fnew && !miss && !upd) begin
                if (!m_valid[ci]) begin
                    e_req = 1'b1;
                    e_pf = addr + 1;
                end else if (m_use[ci][1]) begin
                    e_req = 1'b1;
                    e_pf = m_conf[ci][1] ? m_succ[ci] : addr + 1;
                end
            end
            assert (req === e_req) else begin
                $display("Error: req expected %h actual %h", e_req, req);
                errors++;
            end
            assert (pf_addr === e_pf) else begin
                $display("Error: pf_addr expected %h actual %h", e_pf, pf_addr);
                errors++;
            end
            if (m_pend) begin
                m_use[m_pidx] = sat_up(m_pctr);
            end else if (upd) begin
                m_use[ui] = useful ? sat_up(m_use[ui]) : sat_down(m_use[ui]);
            end
            if (miss) begin
                m_pidx = ai;
                m_pctr = m_use[ai];
            end
            m_pend = miss;
            if (fnew) begin
                m_conf[pi] = (m_valid[pi] && m_succ[pi] == addr) ? sat_up(m_conf[pi])
                                                                : sat_down(m_conf[pi]);
                m_succ[pi] = addr;
                m_valid[pi] = 1'b1;
            end
            m_prev = addr;
        end
    end

    task automatic step(input pf_addr_pkg::addr_t a);
        @(negedge clk);
        addr = a;
        update_en = 1'b0;
        anneal_miss = 1'b0;
        anneal_instr = 1'b0;
    endtask

    task automatic check_out(input logic e_req, input pf_addr_pkg::addr_t e_pf);
        #1;
        assert (req === e_req) else begin
            $display("Error: req expected %h actual %h", e_req, req);
            errors++;
        end
        if (e_req) begin
            assert (pf_addr === e_pf) else begin
                $display("Error: pf_addr expected %h actual %h", e_pf, pf_addr);
                errors++;
            end
        end
    endtask

    task automatic update_use(input pf_addr_pkg::addr_t a, input logic u);
        step(G);
        update_en = 1'b1;
        update_addr = a;
        useful = u;
    endtask

    task automatic wait_for_req(input int limit);
        int n;
        n = 0;
        #1;
        while (!req && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!req) begin
            $display("timeout, no prefetch request within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e;
        int r;
        pf_addr_pkg::addr_t pool [8];
        pool = '{32'h1000, 32'h2004, 32'h3008, 32'h400c,
                 32'h1040, 32'h2044, 32'h5010, 32'h6014};
        repeat (8) @(negedge clk);
        reset = 1'b0;

        e = errors;
        repeat (4) begin
            step(32'h40);
            check_out(1'b0, '0);
        end
        step(32'h5010);
        check_out(1'b1, 32'h5011);
        end_test("reset and first fetch", e);

        e = errors;
        for (int k = 0; k < 5; k++) begin
            step(A);
            check_out(1'b1, (k >= 3) ? B : A + 1);
            step(B);
            step(G);
        end
        end_test("confidence rise", e);

        // alternate successors to walk the counter down
        e = errors;
        step(A);
        check_out(1'b1, B);
        step(C);
        step(G);
        step(A);
        check_out(1'b1, C);
        step(B);
        step(G);
        step(A);
        check_out(1'b1, A + 1);
        end_test("confidence fall", e);

        e = errors;
        update_use(A, 1'b0);
        update_use(A, 1'b0);
        step(A);
        check_out(1'b0, '0);
        update_use(A, 1'b1);
        update_use(A, 1'b1);
        step(A);
        check_out(1'b1, A + 1);
        end_test("usefulness update", e);

        e = errors;
        update_use(A, 1'b0);
        step(A);
        check_out(1'b0, '0);
        step(C);
        anneal_miss = 1'b1;
        anneal_instr = 1'b1;
        anneal_addr = A;
        check_out(1'b0, '0);
        step(G);
        step(A);
        wait_for_req(4);
        update_use(A, 1'b0);
        step(G);
        anneal_miss = 1'b1;
        anneal_instr = 1'b0;
        anneal_addr = A;
        step(G);
        step(A);
        check_out(1'b0, '0);
        end_test("anneal", e);

        e = errors;
        repeat (300) begin
            r = $random(seed);
            step(pool[r[2:0]]);
            update_en = r[8] & r[9];
            useful = r[13];
            update_addr = pool[r[16:14]];
            anneal_miss = r[10] & r[11];
            anneal_instr = r[12];
            anneal_addr = pool[r[19:17]];
        end
        step(G);
        end_test("random run", e);

        @(negedge clk);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== prefetch_predictor_sva.sv ====
`timescale 1ns/10ps

module prefetch_predictor_sva (
    input logic               clk,
    input logic               reset,
    input pf_addr_pkg::addr_t addr,
    input logic               anneal_miss,
    input logic               anneal_instr,
    input logic               req,
    input pf_addr_pkg::addr_t pf_addr
);

    // unchanged fetch address never proposes a prefetch
    assert property (@(posedge clk) disable iff (reset) (addr == $past(addr)) |-> !req)
        else $error("req high with unchanged addr");

    assert property (@(posedge clk) disable iff (reset) !req |-> (pf_addr == '0))
        else $error("pf_addr nonzero while req low");

    // read port belongs to the anneal in the miss cycle
    assert property (@(posedge clk) disable iff (reset) (anneal_miss && anneal_instr) |-> !req)
        else $error("req high in anneal read cycle");

    assert property (@(posedge clk) disable iff (reset) !$isunknown(req))
        else $error("req unknown");

endmodule

bind prefetch_predictor prefetch_predictor_sva prefetch_predictor_sva_i (.*);

// ==== prefetch_predictor.sv ====
`timescale 1ns/10ps

module prefetch_predictor (
    input  logic               clk,
    input  logic               reset,
    input  pf_addr_pkg::addr_t addr,
    input  logic               update_en,
    input  pf_addr_pkg::addr_t update_addr,
    input  logic               useful,
    input  logic               anneal_miss,
    input  logic               anneal_instr,
    input  pf_addr_pkg::addr_t anneal_addr,
    output logic               req,
    output pf_addr_pkg::addr_t pf_addr
);

    logic               fetch_new;
    logic               succ_valid;
    pf_addr_pkg::addr_t succ_addr;
    pf_pred_pkg::ctr2_t succ_ctr;
    pf_pred_pkg::ctr2_t use_ctr;
    logic               use_ready;

    next_addr_table next_addr_table_i (
        .clk       (clk),
        .reset     (reset),
        .addr      (addr),
        .fetch_new (fetch_new),
        .succ_valid(succ_valid),
        .succ_addr (succ_addr),
        .succ_ctr  (succ_ctr)
    );

    usefulness_table usefulness_table_i (
        .clk         (clk),
        .reset       (reset),
        .addr        (addr),
        .update_en   (update_en),
        .update_addr (update_addr),
        .useful      (useful),
        .anneal_miss (anneal_miss),
        .anneal_instr(anneal_instr),
        .anneal_addr (anneal_addr),
        .use_ctr     (use_ctr),
        .use_ready   (use_ready)
    );

    prefetch_decide prefetch_decide_i (
        .addr      (addr),
        .fetch_new (fetch_new),
        .use_ready (use_ready),
        .succ_valid(succ_valid),
        .succ_addr (succ_addr),
        .succ_ctr  (succ_ctr),
        .use_ctr   (use_ctr),
        .req       (req),
        .pf_addr   (pf_addr)
    );

endmodule

// ==== prefetch_decide.sv ====
`timescale 1ns/10ps

module prefetch_decide (
    input  pf_addr_pkg::addr_t addr,
    input  logic               fetch_new,
    input  logic               use_ready,
    input  logic               succ_valid,
    input  pf_addr_pkg::addr_t succ_addr,
    input  pf_pred_pkg::ctr2_t succ_ctr,
    input  pf_pred_pkg::ctr2_t use_ctr,
    output logic               req,
    output pf_addr_pkg::addr_t pf_addr
);

    pf_addr_pkg::addr_t seq_addr;

    // sequential fallback
    assign seq_addr = addr + pf_addr_pkg::addr_t'(1);

    always_comb begin
        req     = 1'b0;
        pf_addr = '0;
        if (fetch_new && use_ready) begin
            if (!succ_valid) begin
                // nothing learned yet
                req     = 1'b1;
                pf_addr = seq_addr;
            end else if (use_ctr[1]) begin
                req     = 1'b1;
                pf_addr = succ_ctr[1] ? succ_addr : seq_addr;
            end
        end
    end

endmodule

// ==== usefulness_table.sv ====
`timescale 1ns/10ps
`include "pf_config.svh"

module usefulness_table (
    input  logic               clk,
    input  logic               reset,
    input  pf_addr_pkg::addr_t addr,
    input  logic               update_en,
    input  pf_addr_pkg::addr_t update_addr,
    input  logic               useful,
    input  logic               anneal_miss,
    input  logic               anneal_instr,
    input  pf_addr_pkg::addr_t anneal_addr,
    output pf_pred_pkg::ctr2_t use_ctr,
    output logic               use_ready
);

    pf_pred_pkg::anneal_state_t state;
    pf_pred_pkg::anneal_state_t state_next;
    logic                       instr_miss;
    logic                       update_read;
    logic                       we;
    pf_addr_pkg::index_t        rd_index;
    pf_addr_pkg::index_t        wr_index;
    pf_addr_pkg::index_t        anneal_index;
    pf_pred_pkg::ctr2_t         anneal_ctr;
    pf_pred_pkg::ctr2_t         rd_ctr;
    pf_pred_pkg::ctr2_t         wr_ctr;

    assign instr_miss = anneal_miss && anneal_instr;

    // the update needs the single read port, so it only goes through
    // with no miss read and no anneal write in the same cycle
    assign update_read = update_en && !instr_miss &&
                         (state == pf_pred_pkg::ANNEAL_IDLE);

    // use_ctr belongs to addr only when the port is not borrowed
    assign use_ready = !instr_miss && !update_read;
    assign use_ctr   = rd_ctr;

    always_comb begin
        if (instr_miss) begin
            rd_index = anneal_addr[`PF_INDEX_WIDTH-1:0];
        end else if (update_read) begin
            rd_index = update_addr[`PF_INDEX_WIDTH-1:0];
        end else begin
            rd_index = addr[`PF_INDEX_WIDTH-1:0];
        end
    end

    // anneal write wins over the update port
    always_comb begin
        we       = 1'b0;
        wr_index = update_addr[`PF_INDEX_WIDTH-1:0];
        wr_ctr   = useful ? pf_pred_pkg::ctr_inc(rd_ctr) : pf_pred_pkg::ctr_dec(rd_ctr);
        if (state == pf_pred_pkg::ANNEAL_WRITE) begin
            we       = 1'b1;
            wr_index = anneal_index;
            wr_ctr   = pf_pred_pkg::ctr_inc(anneal_ctr);
        end else if (update_read) begin
            we = 1'b1;
        end
    end

    pf_table_ram #(
        .DATA_WIDTH($bits(pf_pred_pkg::ctr2_t)),
        .INIT_VALUE(`PF_USE_INIT)
    ) table_ram_i (
        .clk  (clk),
        .reset(reset),
        .raddr(rd_index),
        .rdata(rd_ctr),
        .we   (we),
        .waddr(wr_index),
        .wdata(wr_ctr)
    );

    // read in the miss cycle, write on the next
    assign state_next = instr_miss ? pf_pred_pkg::ANNEAL_WRITE : pf_pred_pkg::ANNEAL_IDLE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pf_pred_pkg::ANNEAL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // back to back misses on one index see the pending write
    always_ff @(posedge clk) begin
        if (instr_miss) begin
            anneal_index <= rd_index;
            anneal_ctr   <= (we && (wr_index == rd_index)) ? wr_ctr : rd_ctr;
        end
    end

endmodule

// ==== next_addr_table.sv ====
`timescale 1ns/10ps
`include "pf_config.svh"

module next_addr_table (
    input  logic               clk,
    input  logic               reset,
    input  pf_addr_pkg::addr_t addr,
    output logic               fetch_new,
    output logic               succ_valid,
    output pf_addr_pkg::addr_t succ_addr,
    output pf_pred_pkg::ctr2_t succ_ctr
);

    // entry is {successor, valid, confidence}
    localparam int ENTRY_WIDTH = $bits(pf_addr_pkg::addr_t) + 1 + $bits(pf_pred_pkg::ctr2_t);
    localparam logic [ENTRY_WIDTH-1:0] ENTRY_INIT = {
        {$bits(pf_addr_pkg::addr_t){1'b0}}, 1'b0, `PF_CONF_INIT
    };

    pf_addr_pkg::addr_t     prev_addr;
    pf_addr_pkg::index_t    rd_index;
    pf_addr_pkg::index_t    wr_index;
    logic [ENTRY_WIDTH-1:0] rd_entry;
    logic [ENTRY_WIDTH-1:0] wr_entry;
    logic [ENTRY_WIDTH-1:0] prev_entry;
    pf_addr_pkg::addr_t     prev_succ;
    logic                   prev_valid;
    pf_pred_pkg::ctr2_t     prev_ctr;
    pf_pred_pkg::ctr2_t     new_ctr;
    logic                   succ_hit;

    assign rd_index  = addr[`PF_INDEX_WIDTH-1:0];
    assign wr_index  = prev_addr[`PF_INDEX_WIDTH-1:0];
    assign fetch_new = (addr != prev_addr);

    assign {succ_addr, succ_valid, succ_ctr} = rd_entry;
    assign {prev_succ, prev_valid, prev_ctr} = prev_entry;

    // same successor as last time raises confidence
    assign succ_hit = prev_valid && (prev_succ == addr);
    assign new_ctr  = succ_hit ? pf_pred_pkg::ctr_inc(prev_ctr)
                               : pf_pred_pkg::ctr_dec(prev_ctr);
    assign wr_entry = {addr, 1'b1, new_ctr};

    pf_table_ram #(
        .DATA_WIDTH(ENTRY_WIDTH),
        .INIT_VALUE(ENTRY_INIT)
    ) table_ram_i (
        .clk  (clk),
        .reset(reset),
        .raddr(rd_index),
        .rdata(rd_entry),
        .we   (fetch_new),
        .waddr(wr_index),
        .wdata(wr_entry)
    );

    // also loaded during reset, so no change is seen right after it
    always_ff @(posedge clk) begin
        prev_addr <= addr;
    end

    // entry of the current address becomes next cycle's training entry;
    // take the write data when this cycle writes the same index
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_entry <= ENTRY_INIT;
        end else if (fetch_new && (rd_index == wr_index)) begin
            prev_entry <= wr_entry;
        end else begin
            prev_entry <= rd_entry;
        end
    end

endmodule

// ==== pf_table_ram.sv ====
`timescale 1ns/10ps

module pf_table_ram #(
    parameter int DATA_WIDTH = 2,
    parameter logic [DATA_WIDTH-1:0] INIT_VALUE = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  pf_addr_pkg::index_t   raddr,
    output logic [DATA_WIDTH-1:0] rdata,
    input  logic                  we,
    input  pf_addr_pkg::index_t   waddr,
    input  logic [DATA_WIDTH-1:0] wdata
);

    localparam int DEPTH = 2 ** $bits(pf_addr_pkg::index_t);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // combinational read
    assign rdata = mem[raddr];

    // every entry back to its initial value while reset is high
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= INIT_VALUE;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

// ==== pf_pred_pkg.sv ====
package pf_pred_pkg;

    // 2-bit saturating counter, msb is the decision
    typedef logic [1:0] ctr2_t;

    // anneal sequencer
    typedef enum logic {
        ANNEAL_IDLE,
        ANNEAL_WRITE
    } anneal_state_t;

    // saturates at 11
    function automatic ctr2_t ctr_inc(ctr2_t c);
        return (c == 2'b11) ? c : c + 2'b01;
    endfunction

    // saturates at 00
    function automatic ctr2_t ctr_dec(ctr2_t c);
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

endpackage

// ==== pf_addr_pkg.sv ====
`include "pf_config.svh"

package pf_addr_pkg;

    // fetch or prefetch address
    typedef logic [`PF_ADDR_WIDTH-1:0] addr_t;

    // table index, low bits of an address
    typedef logic [`PF_INDEX_WIDTH-1:0] index_t;

endpackage

// ==== pf_config.svh ====
`ifndef PF_CONFIG_SVH
`define PF_CONFIG_SVH

// fetch address width
`define PF_ADDR_WIDTH 32

// low address bits indexing both tables, 64 entries
`define PF_INDEX_WIDTH 6

// counter reset values
`define PF_USE_INIT 2'b10
`define PF_CONF_INIT 2'b00

`endif
